// File: verilog/mips_pkg.sv
package mips_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////////////////////////
	localparam int len_exec_bus = 11;
	localparam int len_mem_bus  = 9;
	localparam int len_wb_bus   = 2;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [2:0]  aluop_t;    // Operation class from main decoder
	typedef logic [3:0]  alu_code_t;

	// link, jal_only, reg_dst, alu_src1, alu_src2, jump, jump_reg, alu code
	typedef logic [len_exec_bus-1:0] exec_bus_t;
	// bne, sb, sh, lb, lh, unsigned, branch, mem_read, mem_write
	typedef logic [len_mem_bus-1:0]  mem_bus_t;
	// reg_write, mem_to_reg
	typedef logic [len_wb_bus-1:0]   wb_bus_t;

	//////////////////////////////////////////////////////////////////////
	// Major opcodes
	//////////////////////////////////////////////////////////////////////
	localparam opcode_t op_rtype = 6'b000000;
	localparam opcode_t op_j     = 6'b000010;
	localparam opcode_t op_jal   = 6'b000011;
	localparam opcode_t op_beq   = 6'b000100;
	localparam opcode_t op_bne   = 6'b000101;
	localparam opcode_t op_addi  = 6'b001000;
	localparam opcode_t op_slti  = 6'b001010;
	localparam opcode_t op_andi  = 6'b001100;
	localparam opcode_t op_ori   = 6'b001101;
	localparam opcode_t op_xori  = 6'b001110;
	localparam opcode_t op_lui   = 6'b001111;
	localparam opcode_t op_lb    = 6'b100000;
	localparam opcode_t op_lh    = 6'b100001;
	localparam opcode_t op_lw    = 6'b100011;
	localparam opcode_t op_lbu   = 6'b100100;
	localparam opcode_t op_lhu   = 6'b100101;
	localparam opcode_t op_lwu   = 6'b100111;
	localparam opcode_t op_sb    = 6'b101000;
	localparam opcode_t op_sh    = 6'b101001;
	localparam opcode_t op_sw    = 6'b101011;

	// R-type function field
	localparam funct_t fn_sll  = 6'b000000;
	localparam funct_t fn_srl  = 6'b000010;
	localparam funct_t fn_sra  = 6'b000011;
	localparam funct_t fn_sllv = 6'b000100;
	localparam funct_t fn_srlv = 6'b000110;
	localparam funct_t fn_srav = 6'b000111;
	localparam funct_t fn_jr   = 6'b001000;
	localparam funct_t fn_jalr = 6'b001001;
	localparam funct_t fn_add  = 6'b100000;
	localparam funct_t fn_addu = 6'b100001;
	localparam funct_t fn_sub  = 6'b100010;
	localparam funct_t fn_subu = 6'b100011;
	localparam funct_t fn_and  = 6'b100100;
	localparam funct_t fn_or   = 6'b100101;
	localparam funct_t fn_xor  = 6'b100110;
	localparam funct_t fn_nor  = 6'b100111;
	localparam funct_t fn_slt  = 6'b101010;
	localparam funct_t fn_sltu = 6'b101011;

	// ALU function select
	localparam alu_code_t alu_sll  = 4'd0;
	localparam alu_code_t alu_srl  = 4'd1;
	localparam alu_code_t alu_sra  = 4'd2;
	localparam alu_code_t alu_add  = 4'd3;
	localparam alu_code_t alu_sub  = 4'd4;
	localparam alu_code_t alu_and  = 4'd5;
	localparam alu_code_t alu_or   = 4'd6;
	localparam alu_code_t alu_xor  = 4'd7;
	localparam alu_code_t alu_nor  = 4'd8;
	localparam alu_code_t alu_slt  = 4'd9;
	localparam alu_code_t alu_sltu = 4'd10;
	localparam alu_code_t alu_lui  = 4'd11;
	localparam alu_code_t alu_sllv = 4'd12;
	localparam alu_code_t alu_srlv = 4'd13;
	localparam alu_code_t alu_srav = 4'd14;
	localparam alu_code_t alu_addu = 4'd15;

	// Operation classes, 101 unused
	localparam aluop_t aop_funct = 3'b000;
	localparam aluop_t aop_add   = 3'b001;
	localparam aluop_t aop_and   = 3'b010;
	localparam aluop_t aop_or    = 3'b011;
	localparam aluop_t aop_xor   = 3'b100;
	localparam aluop_t aop_slt   = 3'b110;
	localparam aluop_t aop_lui   = 3'b111;

endpackage

// File: verilog/alu_control.sv
`timescale 1ns/10ps

module alu_control
(
	input  mips_pkg::funct_t    opcode_lsb,
	input  mips_pkg::aluop_t    aluop,
	output mips_pkg::alu_code_t alu_code
);
	import mips_pkg::*;

	alu_code_t funct_code; // Code picked by the R-type function field

	always_comb
	begin
		case (opcode_lsb)
			fn_sll:  funct_code = alu_sll;
			fn_srl:  funct_code = alu_srl;
			fn_sra:  funct_code = alu_sra;
			fn_sllv: funct_code = alu_sllv;
			fn_srlv: funct_code = alu_srlv;
			fn_srav: funct_code = alu_srav;
			fn_add:  funct_code = alu_add;
			fn_addu: funct_code = alu_addu;
			fn_sub:  funct_code = alu_sub;
			fn_subu: funct_code = alu_sub;
			fn_and:  funct_code = alu_and;
			fn_or:   funct_code = alu_or;
			fn_xor:  funct_code = alu_xor;
			fn_nor:  funct_code = alu_nor;
			fn_slt:  funct_code = alu_slt;
			fn_sltu: funct_code = alu_sltu;
			fn_jr, fn_jalr: funct_code = alu_add; // Link address computation
			default: funct_code = alu_add;
		endcase
	end

	// Non R-type classes ignore the function field
	always_comb
	begin
		case (aluop)
			aop_funct: alu_code = funct_code;
			aop_add:   alu_code = alu_add;
			aop_and:   alu_code = alu_and;
			aop_or:    alu_code = alu_or;
			aop_xor:   alu_code = alu_xor;
			aop_slt:   alu_code = alu_slt;
			aop_lui:   alu_code = alu_lui;
			default:   alu_code = alu_add;
		endcase
	end

endmodule

// File: verilog/control.sv
`timescale 1ns/10ps

module control
(
	input  mips_pkg::opcode_t   opcode,
	input  mips_pkg::funct_t    opcode_lsb,
	output mips_pkg::exec_bus_t execute_bus,
	output mips_pkg::mem_bus_t  memory_bus,
	output mips_pkg::wb_bus_t   writeback_bus
);
	import mips_pkg::*;

	// One decode row: execute flags, operation class, memory bus, write-back bus
	localparam int row_w = len_exec_bus - 4 + $bits(aluop_t) + len_mem_bus + len_wb_bus;

	logic [row_w-1:0]        ctl_row;
	logic [len_exec_bus-1:4] exec_ctl;
	aluop_t                  aluop;
	alu_code_t               alu_code;
	logic                    known_op;

	alu_control u_alu_control
	(
		.opcode_lsb (opcode_lsb),
		.aluop      (aluop),
		.alu_code   (alu_code)
	);

	//////////////////////////////////////////////////////////////////////
	// Decode table
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		known_op = 1'b1;
		case (opcode)
			op_rtype:
			begin
				case (opcode_lsb)
					fn_sll, fn_srl, fn_sra:
						ctl_row = {7'b0011000, aop_funct, 9'b000000000, 2'b10}; // Shift by shamt
					fn_jr:
						ctl_row = {7'b0000001, aop_funct, 9'b000000000, 2'b10};
					fn_jalr:
						ctl_row = {7'b1010001, aop_funct, 9'b000000000, 2'b10};
					default:
						ctl_row = {7'b0010000, aop_funct, 9'b000000000, 2'b10};
				endcase
			end
			// Loads
			op_lb:          ctl_row = {7'b0000100, aop_add, 9'b000100010, 2'b11};
			op_lh:          ctl_row = {7'b0000100, aop_add, 9'b000010010, 2'b11};
			op_lw, op_lwu:  ctl_row = {7'b0000100, aop_add, 9'b000000010, 2'b11};
			op_lbu:         ctl_row = {7'b0000100, aop_add, 9'b000101010, 2'b11};
			op_lhu:         ctl_row = {7'b0000100, aop_add, 9'b000011010, 2'b11};
			// Stores
			op_sb:          ctl_row = {7'b0000100, aop_add, 9'b010000001, 2'b00};
			op_sh:          ctl_row = {7'b0000100, aop_add, 9'b001000001, 2'b00};
			op_sw:          ctl_row = {7'b0000100, aop_add, 9'b000000001, 2'b00};
			// ALU with immediate
			op_addi:        ctl_row = {7'b0000100, aop_add, 9'b000000100, 2'b10};
			op_andi:        ctl_row = {7'b0000100, aop_and, 9'b000000100, 2'b10};
			op_ori:         ctl_row = {7'b0000100, aop_or,  9'b000000100, 2'b10};
			op_xori:        ctl_row = {7'b0000100, aop_xor, 9'b000000100, 2'b10};
			op_lui:         ctl_row = {7'b0000100, aop_lui, 9'b000000100, 2'b10};
			op_slti:        ctl_row = {7'b0000100, aop_slt, 9'b000000000, 2'b10};
			// Branches and jumps
			op_beq:         ctl_row = {7'b0000000, aop_slt, 9'b000000100, 2'b00};
			op_bne:         ctl_row = {7'b0000000, aop_slt, 9'b100000100, 2'b00};
			op_j:           ctl_row = {7'b0000010, aop_funct, 9'b000000100, 2'b00};
			op_jal:         ctl_row = {7'b1100010, aop_add, 9'b000000000, 2'b10};
			default:
			begin
				ctl_row  = '0;
				known_op = 1'b0; // Also blanks the ALU code
			end
		endcase
	end

	assign {exec_ctl, aluop, memory_bus, writeback_bus} = ctl_row;
	assign execute_bus = {exec_ctl, known_op ? alu_code : alu_code_t'(0)};

	// Bit 5 jump, bit 4 jump_register
	always_comb
	begin
		assert #0 (!(execute_bus[5] && execute_bus[4]))
			else $error("jump and jump_register both set, opcode %b", opcode);
	end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/10ps

module register_file
(
	input  logic                clk,
	input  logic                reset,
	input  mips_pkg::reg_addr_t rs_addr,
	input  mips_pkg::reg_addr_t rt_addr,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data,
	input  logic                wb_en,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t     wb_data
);
	import mips_pkg::*;

	word_t regs [1:31]; // Register zero is not stored

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb_en && wb_addr != '0)
			regs[wb_addr] <= wb_data;
	end

	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (wb_en && wb_addr == addr)
			return wb_data; // Write-through
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

	// Register zero stays zero on both ports, also while it is written
	zero_reads_zero: assert property (@(posedge clk) disable iff (reset)
		(rs_addr != '0 || rs_data == '0) && (rt_addr != '0 || rt_data == '0));

endmodule

// File: verilog/id_ex_register.sv
`timescale 1ns/10ps

module id_ex_register
(
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                flush,
	input  logic                instr_valid,
	input  mips_pkg::opcode_t   opcode,
	input  mips_pkg::exec_bus_t execute_bus,
	input  mips_pkg::mem_bus_t  memory_bus,
	input  mips_pkg::wb_bus_t   writeback_bus,
	input  mips_pkg::word_t     rs_data,
	input  mips_pkg::word_t     rt_data,
	input  logic [15:0]         imm,
	input  mips_pkg::reg_addr_t rs_addr,
	input  mips_pkg::reg_addr_t rt_addr,
	input  mips_pkg::reg_addr_t rd_addr,
	input  logic [4:0]          shamt,
	output logic                ex_valid,
	output mips_pkg::exec_bus_t ex_execute_bus,
	output mips_pkg::mem_bus_t  ex_memory_bus,
	output mips_pkg::wb_bus_t   ex_writeback_bus,
	output mips_pkg::word_t     ex_rs_data,
	output mips_pkg::word_t     ex_rt_data,
	output mips_pkg::word_t     ex_imm,
	output mips_pkg::reg_addr_t ex_rs_addr,
	output mips_pkg::reg_addr_t ex_rt_addr,
	output mips_pkg::reg_addr_t ex_rd_addr,
	output logic [4:0]          ex_shamt
);
	import mips_pkg::*;

	word_t imm_ext;

	// Logical immediates are zero-extended
	always_comb
	begin
		case (opcode)
			op_andi, op_ori, op_xori: imm_ext = {16'h0000, imm};
			default:                  imm_ext = {{16{imm[15]}}, imm};
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control half, flush wins over stall
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			ex_valid         <= 1'b0;
			ex_execute_bus   <= '0;
			ex_memory_bus    <= '0;
			ex_writeback_bus <= '0;
		end
		else if (!stall)
		begin
			ex_valid         <= instr_valid;
			ex_execute_bus   <= execute_bus;
			ex_memory_bus    <= memory_bus;
			ex_writeback_bus <= writeback_bus;
		end
	end

	// Data half
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			ex_rs_data <= rs_data;
			ex_rt_data <= rt_data;
			ex_imm     <= imm_ext;
			ex_rs_addr <= rs_addr;
			ex_rt_addr <= rt_addr;
			ex_rd_addr <= rd_addr;
			ex_shamt   <= shamt;
		end
	end

	flush_kills: assert property (@(posedge clk) disable iff (reset)
		flush |=> !ex_valid);

	stall_holds: assert property (@(posedge clk) disable iff (reset)
		(stall && !flush) |=>
			$stable({ex_valid, ex_execute_bus, ex_memory_bus, ex_writeback_bus}));

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
(
	input  logic                clk,
	input  logic                reset,
	input  mips_pkg::word_t     instr,
	input  logic                instr_valid,
	input  logic                stall,
	input  logic                flush,
	input  logic                wb_en,
	input  mips_pkg::reg_addr_t wb_addr,
	input  mips_pkg::word_t     wb_data,
	output logic                ex_valid,
	output mips_pkg::exec_bus_t ex_execute_bus,
	output mips_pkg::mem_bus_t  ex_memory_bus,
	output mips_pkg::wb_bus_t   ex_writeback_bus,
	output mips_pkg::word_t     ex_rs_data,
	output mips_pkg::word_t     ex_rt_data,
	output mips_pkg::word_t     ex_imm,
	output mips_pkg::reg_addr_t ex_rs_addr,
	output mips_pkg::reg_addr_t ex_rt_addr,
	output mips_pkg::reg_addr_t ex_rd_addr,
	output logic [4:0]          ex_shamt
);
	import mips_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////////////////////////
	opcode_t     opcode;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [4:0]  shamt;
	funct_t      funct;
	logic [15:0] imm;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign funct  = instr[5:0];
	assign imm    = instr[15:0]; // Extended in the pipeline register

	exec_bus_t execute_bus;
	mem_bus_t  memory_bus;
	wb_bus_t   writeback_bus;
	word_t     rs_data;
	word_t     rt_data;

	control u_control
	(
		.opcode        (opcode),
		.opcode_lsb    (funct),
		.execute_bus   (execute_bus),
		.memory_bus    (memory_bus),
		.writeback_bus (writeback_bus)
	);

	register_file u_register_file
	(
		.clk     (clk),
		.reset   (reset),
		.rs_addr (rs),
		.rt_addr (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	id_ex_register u_id_ex_register
	(
		.clk              (clk),
		.reset            (reset),
		.stall            (stall),
		.flush            (flush),
		.instr_valid      (instr_valid),
		.opcode           (opcode),
		.execute_bus      (execute_bus),
		.memory_bus       (memory_bus),
		.writeback_bus    (writeback_bus),
		.rs_data          (rs_data),
		.rt_data          (rt_data),
		.imm              (imm),
		.rs_addr          (rs),
		.rt_addr          (rt),
		.rd_addr          (rd),
		.shamt            (shamt),
		.ex_valid         (ex_valid),
		.ex_execute_bus   (ex_execute_bus),
		.ex_memory_bus    (ex_memory_bus),
		.ex_writeback_bus (ex_writeback_bus),
		.ex_rs_data       (ex_rs_data),
		.ex_rt_data       (ex_rt_data),
		.ex_imm           (ex_imm),
		.ex_rs_addr       (ex_rs_addr),
		.ex_rt_addr       (ex_rt_addr),
		.ex_rd_addr       (ex_rd_addr),
		.ex_shamt         (ex_shamt)
	);

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
#(
	parameter int period = 40 // In ns
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(period / 2) clk = ~clk;
	end

endmodule

// File: dv/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;
	import mips_pkg::*;

	localparam int    max_lines     = 400;
	localparam int    reset_timeout = 50;
	localparam word_t idle_instr    = 32'hfc00_0000; // Unknown opcode, decodes to zero buses
	localparam word_t reset_instr   = 32'h0022_1820; // Add, nonzero buses while in reset

	logic      clk;
	logic      reset;
	word_t     instr;
	logic      instr_valid;
	logic      stall;
	logic      flush;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      ex_valid;
	exec_bus_t ex_execute_bus;
	mem_bus_t  ex_memory_bus;
	wb_bus_t   ex_writeback_bus;
	word_t     ex_rs_data;
	word_t     ex_rt_data;
	word_t     ex_imm;
	reg_addr_t ex_rs_addr;
	reg_addr_t ex_rt_addr;
	reg_addr_t ex_rd_addr;
	logic [4:0] ex_shamt;

	int    fd;
	int    vector_count;
	word_t held_instr;   // Instruction whose fields sit in the ID/EX register
	logic  fields_known;

	// Columns of one vector line
	word_t v_instr, v_valid, v_stall, v_flush, v_wb_en, v_wb_addr, v_wb_data;
	word_t e_valid, e_exec, e_mem, e_wb, e_rs, e_rt, e_imm;

	tb_clock #(.period(40)) clock0 (.clk(clk));

	decode_stage dut0
	(
		.clk              (clk),
		.reset            (reset),
		.instr            (instr),
		.instr_valid      (instr_valid),
		.stall            (stall),
		.flush            (flush),
		.wb_en            (wb_en),
		.wb_addr          (wb_addr),
		.wb_data          (wb_data),
		.ex_valid         (ex_valid),
		.ex_execute_bus   (ex_execute_bus),
		.ex_memory_bus    (ex_memory_bus),
		.ex_writeback_bus (ex_writeback_bus),
		.ex_rs_data       (ex_rs_data),
		.ex_rt_data       (ex_rt_data),
		.ex_imm           (ex_imm),
		.ex_rs_addr       (ex_rs_addr),
		.ex_rt_addr       (ex_rt_addr),
		.ex_rd_addr       (ex_rd_addr),
		.ex_shamt         (ex_shamt)
	);

	//////////////////////////////////////////////////////////////////////
	// Checking and failure helpers
	//////////////////////////////////////////////////////////////////////
	task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAIL %0t: vector %0d, %s is %h, expected %h",
				$time, vector_count, name, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task abort_run(input string reason);
		$display("Run aborted: %s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "%s", reason);
	endtask

	// Next non-blank character of the data file, -1 at end of file
	function automatic int next_char();
		int c;
		c = $fgetc(fd);
		while (c == " " || c == "\t" || c == "\n" || c == "\r")
			c = $fgetc(fd);
		return c;
	endfunction

	task skip_line();
		int c;
		c = $fgetc(fd);
		while (c != "\n" && c != -1)
			c = $fgetc(fd);
	endtask

	// Returns on the falling edge that releases reset
	task wait_reset_release();
		int cycles;
		cycles = 0;
		while (reset !== 1'b0 && cycles < reset_timeout)
		begin
			@(negedge clk or negedge reset);
			cycles++;
		end
		if (reset !== 1'b0)
			abort_run("timed out waiting for reset release");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus, always entered on a falling edge
	//////////////////////////////////////////////////////////////////////
	task preload_register(input word_t addr, input word_t data);
		instr_valid = 1'b0; // Bubble while the write-back port loads
		stall       = 1'b0;
		flush       = 1'b0;
		wb_en       = 1'b1;
		wb_addr     = addr[4:0];
		wb_data     = data;
		@(posedge clk);
		@(negedge clk);
		wb_en      = 1'b0;
		held_instr = instr;
	endtask

	task apply_vector();
		instr       = v_instr;
		instr_valid = v_valid[0];
		stall       = v_stall[0];
		flush       = v_flush[0];
		wb_en       = v_wb_en[0];
		wb_addr     = v_wb_addr[4:0];
		wb_data     = v_wb_data;
		@(posedge clk);
		@(negedge clk);
		if (v_flush[0])
			fields_known = 1'b0;
		else if (!v_stall[0])
		begin
			held_instr   = v_instr;
			fields_known = 1'b1;
		end
		check_value("ex_valid", ex_valid, e_valid);
		check_value("ex_execute_bus", ex_execute_bus, e_exec);
		check_value("ex_memory_bus", ex_memory_bus, e_mem);
		check_value("ex_writeback_bus", ex_writeback_bus, e_wb);
		// Data fields are left open by a flush
		if (!v_flush[0] && fields_known)
		begin
			check_value("ex_rs_data", ex_rs_data, e_rs);
			check_value("ex_rt_data", ex_rt_data, e_rt);
			check_value("ex_imm", ex_imm, e_imm);
			check_value("ex_rs_addr", ex_rs_addr, held_instr[25:21]);
			check_value("ex_rt_addr", ex_rt_addr, held_instr[20:16]);
			check_value("ex_rd_addr", ex_rd_addr, held_instr[15:11]);
			check_value("ex_shamt", ex_shamt, held_instr[10:6]);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

	initial
	begin
		int   ch;
		int   n;
		int   lines;
		logic done;
		word_t p_addr;
		word_t p_data;

		vector_count = 0;
		fields_known = 1'b0;
		held_instr   = idle_instr;
		instr        = reset_instr;
		instr_valid  = 1'b1; // Reset alone must keep the ID/EX control half at zero
		stall        = 1'b0;
		flush        = 1'b0;
		wb_en        = 1'b0;
		wb_addr      = '0;
		wb_data      = '0;

		fd = $fopen("dv/decode_input.txt", "r");
		if (fd == 0)
			abort_run("cannot open the stimulus file dv/decode_input.txt");

		wait_reset_release();
		instr       = idle_instr;
		instr_valid = 1'b0;
		check_value("ex_valid after reset", ex_valid, 0);
		check_value("ex_execute_bus after reset", ex_execute_bus, 0);
		check_value("ex_memory_bus after reset", ex_memory_bus, 0);
		check_value("ex_writeback_bus after reset", ex_writeback_bus, 0);

		lines = 0;
		done  = 1'b0;
		while (!done && lines < max_lines)
		begin
			ch = next_char();
			if (ch == -1)
				done = 1'b1;
			else if (ch == "#")
				skip_line();
			else if (ch == "P")
			begin
				n = $fscanf(fd, "%h %h", p_addr, p_data);
				if (n != 2)
					abort_run("malformed preload line in the stimulus file");
				preload_register(p_addr, p_data);
			end
			else if (ch == "V")
			begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v_instr, v_valid, v_stall, v_flush, v_wb_en, v_wb_addr, v_wb_data,
					e_valid, e_exec, e_mem, e_wb, e_rs, e_rt, e_imm);
				if (n != 14)
					abort_run("malformed vector line in the stimulus file");
				vector_count++;
				apply_vector();
			end
			else
				abort_run("unknown line kind in the stimulus file");
			lines++;
		end
		$fclose(fd);

		if (!done)
			abort_run("stimulus file has too many lines");
		if (vector_count == 0)
			abort_run("no vectors found in the stimulus file");

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: files.f
verilog/mips_pkg.sv
verilog/alu_control.sv
verilog/control.sv
verilog/register_file.sv
verilog/id_ex_register.sv
verilog/decode_stage.sv
dv/tb_clock.sv
dv/decode_stage_tb.sv

// File: dv/decode_input.txt
# P reg value : preload a register through the write-back port
# V instr valid stall flush wb_en wb_addr wb_data exp_valid exp_exec exp_mem exp_wb exp_rs exp_rt exp_imm
P 01 11111111
P 02 22222222
P 03 80000001
P 05 DEADBEEF
P 00 FFFFFFFF
# R-type with rs=1 rt=2 rd=3, shifts use shamt=4
V 00221900 1 0 0 0 00 00000000 1 180 000 2 11111111 22222222 00001900
V 00221902 1 0 0 0 00 00000000 1 181 000 2 11111111 22222222 00001902
V 00221903 1 0 0 0 00 00000000 1 182 000 2 11111111 22222222 00001903
V 00221820 1 0 0 0 00 00000000 1 103 000 2 11111111 22222222 00001820
V 00221821 1 0 0 0 00 00000000 1 10F 000 2 11111111 22222222 00001821
V 00221822 1 0 0 0 00 00000000 1 104 000 2 11111111 22222222 00001822
V 00221823 1 0 0 0 00 00000000 1 104 000 2 11111111 22222222 00001823
V 00221824 1 0 0 0 00 00000000 1 105 000 2 11111111 22222222 00001824
V 00221825 1 0 0 0 00 00000000 1 106 000 2 11111111 22222222 00001825
V 00221826 1 0 0 0 00 00000000 1 107 000 2 11111111 22222222 00001826
V 00221827 1 0 0 0 00 00000000 1 108 000 2 11111111 22222222 00001827
V 0022182A 1 0 0 0 00 00000000 1 109 000 2 11111111 22222222 0000182A
V 0022182B 1 0 0 0 00 00000000 1 10A 000 2 11111111 22222222 0000182B
V 00221804 1 0 0 0 00 00000000 1 10C 000 2 11111111 22222222 00001804
V 00221806 1 0 0 0 00 00000000 1 10D 000 2 11111111 22222222 00001806
V 00221807 1 0 0 0 00 00000000 1 10E 000 2 11111111 22222222 00001807
V 00221808 1 0 0 0 00 00000000 1 013 000 2 11111111 22222222 00001808
V 00221809 1 0 0 0 00 00000000 1 513 000 2 11111111 22222222 00001809
V 0022183F 1 0 0 0 00 00000000 1 103 000 2 11111111 22222222 0000183F
# Loads and stores
V 80228004 1 0 0 0 00 00000000 1 043 022 3 11111111 22222222 FFFF8004
V 84220010 1 0 0 0 00 00000000 1 043 012 3 11111111 22222222 00000010
V 8C220004 1 0 0 0 00 00000000 1 043 002 3 11111111 22222222 00000004
V 90220001 1 0 0 0 00 00000000 1 043 02A 3 11111111 22222222 00000001
V 94220002 1 0 0 0 00 00000000 1 043 01A 3 11111111 22222222 00000002
V 9C22FFFC 1 0 0 0 00 00000000 1 043 002 3 11111111 22222222 FFFFFFFC
V A0220003 1 0 0 0 00 00000000 1 043 081 0 11111111 22222222 00000003
V A4220006 1 0 0 0 00 00000000 1 043 041 0 11111111 22222222 00000006
V AC220008 1 0 0 0 00 00000000 1 043 001 0 11111111 22222222 00000008
# ALU immediates, logical ones zero-extend
V 2022FFFF 1 0 0 0 00 00000000 1 043 004 2 11111111 22222222 FFFFFFFF
V 3022F0F0 1 0 0 0 00 00000000 1 045 004 2 11111111 22222222 0000F0F0
V 34228001 1 0 0 0 00 00000000 1 046 004 2 11111111 22222222 00008001
V 3822FFFF 1 0 0 0 00 00000000 1 047 004 2 11111111 22222222 0000FFFF
V 3C221234 1 0 0 0 00 00000000 1 04B 004 2 11111111 22222222 00001234
V 28228000 1 0 0 0 00 00000000 1 049 000 2 11111111 22222222 FFFF8000
# Branches, jumps and an unknown opcode
V 1022FFF0 1 0 0 0 00 00000000 1 009 004 0 11111111 22222222 FFFFFFF0
V 14220010 1 0 0 0 00 00000000 1 009 104 0 11111111 22222222 00000010
V 08000040 1 0 0 0 00 00000000 1 020 004 0 00000000 00000000 00000040
V 0C000080 1 0 0 0 00 00000000 1 623 000 2 00000000 00000000 00000080
V FC221234 1 0 0 0 00 00000000 1 000 000 0 11111111 22222222 00001234
# Register zero, unloaded registers and write-through
V 00032020 1 0 0 0 00 00000000 1 103 000 2 00000000 80000001 00002020
V 00032020 1 0 0 1 00 12345678 1 103 000 2 00000000 80000001 00002020
V 00E84820 1 0 0 0 00 00000000 1 103 000 2 00000000 00000000 00004820
V 00853025 1 0 0 1 04 CAFEF00D 1 106 000 2 CAFEF00D DEADBEEF 00003025
V 00853025 1 0 0 0 00 00000000 1 106 000 2 CAFEF00D DEADBEEF 00003025
# Stall holds the add, then flush alone and flush with stall
V 00221820 1 0 0 0 00 00000000 1 103 000 2 11111111 22222222 00001820
V 00221822 1 1 0 0 00 00000000 1 103 000 2 11111111 22222222 00001820
V 00221822 1 1 0 0 00 00000000 1 103 000 2 11111111 22222222 00001820
V 00221822 1 0 0 0 00 00000000 1 104 000 2 11111111 22222222 00001822
V 8C220004 1 0 1 0 00 00000000 0 000 000 0 00000000 00000000 00000000
V 8C220004 1 1 1 0 00 00000000 0 000 000 0 00000000 00000000 00000000
V 8C220004 1 0 0 0 00 00000000 1 043 002 3 11111111 22222222 00000004
# Invalid slot still carries its buses
V 2022FFFF 0 0 0 0 00 00000000 0 043 004 2 11111111 22222222 FFFFFFFF
